/* common/id_pkg.sv */
package id_pkg;

  // fixed RV32I widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;
  localparam int EXC_OP_W   = 4;
  localparam int ALU_OP_W   = 5;
  localparam int MEM_OP_W   = 4;

  // funct7 values used by op and op_imm shifts
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // system words matched in full
  localparam logic [XLEN-1:0] INST_ECALL  = 32'h0000_0073;
  localparam logic [XLEN-1:0] INST_EBREAK = 32'h0010_0073;
  localparam logic [XLEN-1:0] INST_MRET   = 32'h3020_0073;

  // RV32I major opcodes
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // execute class
  typedef enum logic [EXC_OP_W-1:0] {
    EXC_NONE,
    EXC_LUI,
    EXC_AUIPC,
    EXC_JAL,
    EXC_JALR,
    EXC_BRANCH,
    EXC_LOAD,
    EXC_STORE,
    EXC_OPIMM,
    EXC_OPREG,
    EXC_SYSTEM
  } exc_op_e;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  typedef enum logic [MEM_OP_W-1:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LBU,
    MEM_LH,
    MEM_LHU,
    MEM_LW,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_op_e;

endpackage

/* decoder/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
  input  logic [id_pkg::XLEN-1:0]       inst_i,
  output logic [id_pkg::REG_ADDR_W-1:0] rs1_idx_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs2_idx_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rd_idx_o,
  output logic [id_pkg::XLEN-1:0]       imm_o,
  output id_pkg::exc_op_e               exc_op_o,
  output id_pkg::alu_op_e               alu_op_o,
  output id_pkg::mem_op_e               mem_op_o,
  output logic                          ecall_o,
  output logic                          ebreak_o,
  output logic                          mret_o,
  output logic                          illegal_o,
  output logic                          is_call_o
);

  import id_pkg::*;

  // encoding forms
  typedef enum logic [2:0] {
    FORM_NONE,
    FORM_R,
    FORM_I,
    FORM_S,
    FORM_B,
    FORM_U,
    FORM_J
  } form_e;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1_field;
  logic [REG_ADDR_W-1:0] rs2_field;
  logic [REG_ADDR_W-1:0] rd_field;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  form_e   form;
  exc_op_e exc_op;
  alu_op_e alu_op;
  mem_op_e mem_op;
  logic    is_ecall;
  logic    is_ebreak;
  logic    is_mret;

  assign opcode    = opcode_e'(inst_i[6:0]);
  assign rd_field  = inst_i[11:7];
  assign funct3    = inst_i[14:12];
  assign rs1_field = inst_i[19:15];
  assign rs2_field = inst_i[24:20];
  assign funct7    = inst_i[31:25];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign is_ecall  = (inst_i == INST_ECALL);
  assign is_ebreak = (inst_i == INST_EBREAK);
  assign is_mret   = (inst_i == INST_MRET);

  always_comb begin
    form   = FORM_NONE;
    exc_op = EXC_NONE;
    alu_op = ALU_NONE;
    mem_op = MEM_NONE;
    case (opcode)
      OPC_LUI: begin
        form   = FORM_U;
        exc_op = EXC_LUI;
        alu_op = ALU_ADD;
      end
      OPC_AUIPC: begin
        form   = FORM_U;
        exc_op = EXC_AUIPC;
        alu_op = ALU_ADD;
      end
      OPC_JAL: begin
        form   = FORM_J;
        exc_op = EXC_JAL;
        alu_op = ALU_ADD;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          form   = FORM_I;
          exc_op = EXC_JALR;
          alu_op = ALU_ADD;
        end
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  alu_op = ALU_BEQ;
          3'b001:  alu_op = ALU_BNE;
          3'b100:  alu_op = ALU_BLT;
          3'b101:  alu_op = ALU_BGE;
          3'b110:  alu_op = ALU_BLTU;
          3'b111:  alu_op = ALU_BGEU;
          default: alu_op = ALU_NONE;
        endcase
        if (alu_op != ALU_NONE) begin
          form   = FORM_B;
          exc_op = EXC_BRANCH;
        end
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  mem_op = MEM_LB;
          3'b001:  mem_op = MEM_LH;
          3'b010:  mem_op = MEM_LW;
          3'b100:  mem_op = MEM_LBU;
          3'b101:  mem_op = MEM_LHU;
          default: mem_op = MEM_NONE;
        endcase
        // address is rs1 + imm
        if (mem_op != MEM_NONE) begin
          form   = FORM_I;
          exc_op = EXC_LOAD;
          alu_op = ALU_ADD;
        end
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  mem_op = MEM_SB;
          3'b001:  mem_op = MEM_SH;
          3'b010:  mem_op = MEM_SW;
          default: mem_op = MEM_NONE;
        endcase
        if (mem_op != MEM_NONE) begin
          form   = FORM_S;
          exc_op = EXC_STORE;
          alu_op = ALU_ADD;
        end
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          // shifts keep funct7 in the immediate field
          3'b001:  alu_op = (funct7 == F7_BASE) ? ALU_SLL : ALU_NONE;
          default: alu_op = (funct7 == F7_BASE) ? ALU_SRL :
                            (funct7 == F7_ALT)  ? ALU_SRA : ALU_NONE;
        endcase
        if (alu_op != ALU_NONE) begin
          form   = FORM_I;
          exc_op = EXC_OPIMM;
        end
      end
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'b000:  alu_op = ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
          endcase
        end else if (funct7 == F7_ALT) begin
          case (funct3)
            3'b000:  alu_op = ALU_SUB;
            3'b101:  alu_op = ALU_SRA;
            default: alu_op = ALU_NONE;
          endcase
        end
        if (alu_op != ALU_NONE) begin
          form   = FORM_R;
          exc_op = EXC_OPREG;
        end
      end
      OPC_SYSTEM: begin
        // csr group decodes as illegal
        if (is_ecall || is_ebreak || is_mret) begin
          form   = FORM_I;
          exc_op = EXC_SYSTEM;
        end
      end
      default: begin
        form = FORM_NONE;
      end
    endcase
  end

  // zero the indices a form has no field for
  assign rs1_idx_o = (form == FORM_R || form == FORM_I || form == FORM_S || form == FORM_B) ?
                     rs1_field : '0;
  assign rs2_idx_o = (form == FORM_R || form == FORM_S || form == FORM_B) ? rs2_field : '0;
  assign rd_idx_o  = (form == FORM_R || form == FORM_I || form == FORM_U || form == FORM_J) ?
                     rd_field : '0;

  always_comb begin
    case (form)
      FORM_I:  imm_o = imm_i;
      FORM_S:  imm_o = imm_s;
      FORM_B:  imm_o = imm_b;
      FORM_U:  imm_o = imm_u;
      FORM_J:  imm_o = imm_j;
      default: imm_o = '0;
    endcase
  end

  assign exc_op_o  = exc_op;
  assign alu_op_o  = alu_op;
  assign mem_op_o  = mem_op;
  assign ecall_o   = is_ecall;
  assign ebreak_o  = is_ebreak;
  assign mret_o    = is_mret;
  assign illegal_o = (form == FORM_NONE);

  // link register written means a call
  assign is_call_o = (exc_op == EXC_JAL || exc_op == EXC_JALR) && (rd_field != '0);

endmodule

/* verilog/operand_bypass.sv */
`timescale 1ns/1ns

module operand_bypass (
  input  logic [id_pkg::REG_ADDR_W-1:0] rs1_idx_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rs2_idx_i,
  input  logic [id_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [id_pkg::XLEN-1:0]       rs2_rdata_i,
  input  logic                          ex_valid_i,
  input  id_pkg::exc_op_e               ex_exc_op_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] ex_rd_idx_i,
  input  logic [id_pkg::XLEN-1:0]       ex_rd_data_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] mem_rd_addr_i,
  input  logic [id_pkg::XLEN-1:0]       mem_rd_data_i,
  output logic [id_pkg::XLEN-1:0]       rs1_data_o,
  output logic [id_pkg::XLEN-1:0]       rs2_data_o,
  output logic                          load_use_o
);

  import id_pkg::*;

  logic rs1_nz;
  logic rs2_nz;
  logic rs1_ex_hit;
  logic rs2_ex_hit;
  logic rs1_mem_hit;
  logic rs2_mem_hit;
  logic ex_is_load;

  // x0 never forwards
  assign rs1_nz = (rs1_idx_i != '0);
  assign rs2_nz = (rs2_idx_i != '0);

  assign rs1_ex_hit  = rs1_nz && ex_valid_i && (rs1_idx_i == ex_rd_idx_i);
  assign rs2_ex_hit  = rs2_nz && ex_valid_i && (rs2_idx_i == ex_rd_idx_i);
  assign rs1_mem_hit = rs1_nz && (rs1_idx_i == mem_rd_addr_i);
  assign rs2_mem_hit = rs2_nz && (rs2_idx_i == mem_rd_addr_i);

  // ex wins over mem, mem over the register file
  assign rs1_data_o = rs1_ex_hit  ? ex_rd_data_i  :
                      rs1_mem_hit ? mem_rd_data_i : rs1_rdata_i;
  assign rs2_data_o = rs2_ex_hit  ? ex_rd_data_i  :
                      rs2_mem_hit ? mem_rd_data_i : rs2_rdata_i;

  // load data is not ready until mem, so stall
  assign ex_is_load = (ex_exc_op_i == EXC_LOAD);
  assign load_use_o = ex_is_load && (rs1_ex_hit || rs2_ex_hit);

endmodule

/* verilog/id_ex_reg.sv */
`timescale 1ns/1ns

module id_ex_reg (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          valid_i,
  input  logic                          stall_i,
  input  logic                          flush_i,
  input  logic [id_pkg::XLEN-1:0]       pc_i,
  input  logic [id_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [id_pkg::XLEN-1:0]       rs2_data_i,
  input  logic [id_pkg::XLEN-1:0]       imm_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rd_idx_i,
  input  id_pkg::exc_op_e               exc_op_i,
  input  id_pkg::alu_op_e               alu_op_i,
  input  id_pkg::mem_op_e               mem_op_i,
  input  logic                          ecall_i,
  input  logic                          ebreak_i,
  input  logic                          mret_i,
  input  logic                          illegal_i,
  output logic                          ex_valid_o,
  output logic [id_pkg::XLEN-1:0]       ex_pc_o,
  output logic [id_pkg::XLEN-1:0]       ex_rs1_data_o,
  output logic [id_pkg::XLEN-1:0]       ex_rs2_data_o,
  output logic [id_pkg::XLEN-1:0]       ex_imm_o,
  output logic [id_pkg::REG_ADDR_W-1:0] ex_rd_idx_o,
  output id_pkg::exc_op_e               ex_exc_op_o,
  output id_pkg::alu_op_e               ex_alu_op_o,
  output id_pkg::mem_op_e               ex_mem_op_o,
  output logic                          ex_ecall_o,
  output logic                          ex_ebreak_o,
  output logic                          ex_mret_o,
  output logic                          ex_illegal_o
);

  import id_pkg::*;

  logic bubble;

  assign bubble = flush_i || stall_i;

  // control side bubbles on reset, flush or stall
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o   <= 1'b0;
      ex_rd_idx_o  <= '0;
      ex_exc_op_o  <= EXC_NONE;
      ex_alu_op_o  <= ALU_NONE;
      ex_mem_op_o  <= MEM_NONE;
      ex_ecall_o   <= 1'b0;
      ex_ebreak_o  <= 1'b0;
      ex_mret_o    <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else if (bubble) begin
      ex_valid_o   <= 1'b0;
      ex_rd_idx_o  <= '0;
      ex_exc_op_o  <= EXC_NONE;
      ex_alu_op_o  <= ALU_NONE;
      ex_mem_op_o  <= MEM_NONE;
      ex_ecall_o   <= 1'b0;
      ex_ebreak_o  <= 1'b0;
      ex_mret_o    <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else begin
      ex_valid_o   <= valid_i;
      ex_rd_idx_o  <= rd_idx_i;
      ex_exc_op_o  <= exc_op_i;
      ex_alu_op_o  <= alu_op_i;
      ex_mem_op_o  <= mem_op_i;
      ex_ecall_o   <= ecall_i;
      ex_ebreak_o  <= ebreak_i;
      ex_mret_o    <= mret_i;
      ex_illegal_o <= illegal_i;
    end
  end

  // operands and pc
  always_ff @(posedge clk_i) begin
    if (!bubble) begin
      ex_pc_o       <= pc_i;
      ex_rs1_data_o <= rs1_data_i;
      ex_rs2_data_o <= rs2_data_i;
      ex_imm_o      <= imm_i;
    end
  end

endmodule

/* verilog/id_stage_top.sv */
`timescale 1ns/1ns

module id_stage_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          valid_i,
  input  logic [id_pkg::XLEN-1:0]       inst_i,
  input  logic [id_pkg::XLEN-1:0]       pc_i,
  output logic [id_pkg::REG_ADDR_W-1:0] rs1_idx_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs2_idx_o,
  input  logic [id_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [id_pkg::XLEN-1:0]       rs2_rdata_i,
  input  logic [id_pkg::XLEN-1:0]       ex_rd_data_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] mem_rd_addr_i,
  input  logic [id_pkg::XLEN-1:0]       mem_rd_data_i,
  input  logic                          flush_i,
  output logic                          stall_o,
  output logic                          ras_push_valid_o,
  output logic [id_pkg::XLEN-1:0]       ras_push_addr_o,
  output logic                          ex_valid_o,
  output logic [id_pkg::XLEN-1:0]       ex_pc_o,
  output logic [id_pkg::XLEN-1:0]       ex_rs1_data_o,
  output logic [id_pkg::XLEN-1:0]       ex_rs2_data_o,
  output logic [id_pkg::XLEN-1:0]       ex_imm_o,
  output logic [id_pkg::REG_ADDR_W-1:0] ex_rd_idx_o,
  output id_pkg::exc_op_e               ex_exc_op_o,
  output id_pkg::alu_op_e               ex_alu_op_o,
  output id_pkg::mem_op_e               ex_mem_op_o,
  output logic                          ex_ecall_o,
  output logic                          ex_ebreak_o,
  output logic                          ex_mret_o,
  output logic                          ex_illegal_o
);

  import id_pkg::*;

  logic [REG_ADDR_W-1:0] rd_idx;
  logic [XLEN-1:0]       imm;
  exc_op_e               exc_op;
  alu_op_e               alu_op;
  mem_op_e               mem_op;
  logic                  ecall;
  logic                  ebreak;
  logic                  mret;
  logic                  illegal;
  logic                  is_call;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic                  load_use;

  inst_decoder u_decoder (
    .inst_i    (inst_i),
    .rs1_idx_o (rs1_idx_o),
    .rs2_idx_o (rs2_idx_o),
    .rd_idx_o  (rd_idx),
    .imm_o     (imm),
    .exc_op_o  (exc_op),
    .alu_op_o  (alu_op),
    .mem_op_o  (mem_op),
    .ecall_o   (ecall),
    .ebreak_o  (ebreak),
    .mret_o    (mret),
    .illegal_o (illegal),
    .is_call_o (is_call)
  );

  // ex address comes from the register's own rd
  operand_bypass u_bypass (
    .rs1_idx_i     (rs1_idx_o),
    .rs2_idx_i     (rs2_idx_o),
    .rs1_rdata_i   (rs1_rdata_i),
    .rs2_rdata_i   (rs2_rdata_i),
    .ex_valid_i    (ex_valid_o),
    .ex_exc_op_i   (ex_exc_op_o),
    .ex_rd_idx_i   (ex_rd_idx_o),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .rs1_data_o    (rs1_data),
    .rs2_data_o    (rs2_data),
    .load_use_o    (load_use)
  );

  assign stall_o = valid_i && load_use;

  // push only for an instruction that really issues
  assign ras_push_valid_o = is_call && valid_i && !stall_o && !flush_i;
  assign ras_push_addr_o  = pc_i + XLEN'(4);

  id_ex_reg u_id_ex (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (valid_i),
    .stall_i       (stall_o),
    .flush_i       (flush_i),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .imm_i         (imm),
    .rd_idx_i      (rd_idx),
    .exc_op_i      (exc_op),
    .alu_op_i      (alu_op),
    .mem_op_i      (mem_op),
    .ecall_i       (ecall),
    .ebreak_i      (ebreak),
    .mret_i        (mret),
    .illegal_i     (illegal),
    .ex_valid_o    (ex_valid_o),
    .ex_pc_o       (ex_pc_o),
    .ex_rs1_data_o (ex_rs1_data_o),
    .ex_rs2_data_o (ex_rs2_data_o),
    .ex_imm_o      (ex_imm_o),
    .ex_rd_idx_o   (ex_rd_idx_o),
    .ex_exc_op_o   (ex_exc_op_o),
    .ex_alu_op_o   (ex_alu_op_o),
    .ex_mem_op_o   (ex_mem_op_o),
    .ex_ecall_o    (ex_ecall_o),
    .ex_ebreak_o   (ex_ebreak_o),
    .ex_mret_o     (ex_mret_o),
    .ex_illegal_o  (ex_illegal_o)
  );

endmodule

/* bench/id_stage_checker.sv */
`timescale 1ns/1ns

module id_stage_checker (
  input logic clk_i,
  input logic arst_n_i,
  input logic flush_i,
  input logic stall_i,
  input logic ex_valid_i,
  input logic ras_push_valid_i
);

  // a held or flushed slot always becomes a bubble
  a_bubble_after_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (stall_i || flush_i) |=> !ex_valid_i
  ) else $error("ex_valid_o high in the cycle after stall_o or flush_i");

  // the load has left ex one cycle later
  a_single_stall: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) stall_i |=> !stall_i
  ) else $error("stall_o high two cycles in a row");

  a_quiet_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> (!stall_i && !ras_push_valid_i && !ex_valid_i)
  ) else $error("stall_o, ras_push_valid_o or ex_valid_o high during reset");

endmodule

bind id_stage_top id_stage_checker u_checker (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .flush_i          (flush_i),
  .stall_i          (stall_o),
  .ex_valid_i       (ex_valid_o),
  .ras_push_valid_i (ras_push_valid_o)
);

/* bench/id_stage_tb.sv */
`timescale 1ns/1ns

module id_stage_tb;

  import id_pkg::*;

  logic        clk;
  logic        arst_n;
  logic        valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [4:0]  rs1_idx;
  logic [4:0]  rs2_idx;
  logic [31:0] rs1_rdata;
  logic [31:0] rs2_rdata;
  logic [31:0] ex_rd_data;
  logic [4:0]  mem_rd_addr;
  logic [31:0] mem_rd_data;
  logic        flush;
  logic        stall;
  logic        ras_push_valid;
  logic [31:0] ras_push_addr;
  logic        ex_valid;
  logic [31:0] ex_pc;
  logic [31:0] ex_rs1_data;
  logic [31:0] ex_rs2_data;
  logic [31:0] ex_imm;
  logic [4:0]  ex_rd_idx;
  exc_op_e     ex_exc_op;
  alu_op_e     ex_alu_op;
  mem_op_e     ex_mem_op;
  logic        ex_ecall;
  logic        ex_ebreak;
  logic        ex_mret;
  logic        ex_illegal;

  logic [15:0] lfsr_q;
  logic [4:0]  idx_mask;
  int          errors;
  int          checks;
  int          tests;
  int          last_stalls;

  // what the id/ex register holds right now
  logic        prev_valid;
  logic [4:0]  prev_rd;
  exc_op_e     prev_exc;

  // expected decode of the current word
  logic [4:0]  exp_rs1;
  logic [4:0]  exp_rs2;
  logic [4:0]  exp_rd;
  logic [31:0] exp_imm;
  exc_op_e     exp_exc;
  alu_op_e     exp_alu;
  mem_op_e     exp_mem;
  logic        exp_ecall;
  logic        exp_ebreak;
  logic        exp_mret;
  logic        exp_illegal;
  logic        exp_call;

  id_stage_top UUT (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .valid_i          (valid),
    .inst_i           (inst),
    .pc_i             (pc),
    .rs1_idx_o        (rs1_idx),
    .rs2_idx_o        (rs2_idx),
    .rs1_rdata_i      (rs1_rdata),
    .rs2_rdata_i      (rs2_rdata),
    .ex_rd_data_i     (ex_rd_data),
    .mem_rd_addr_i    (mem_rd_addr),
    .mem_rd_data_i    (mem_rd_data),
    .flush_i          (flush),
    .stall_o          (stall),
    .ras_push_valid_o (ras_push_valid),
    .ras_push_addr_o  (ras_push_addr),
    .ex_valid_o       (ex_valid),
    .ex_pc_o          (ex_pc),
    .ex_rs1_data_o    (ex_rs1_data),
    .ex_rs2_data_o    (ex_rs2_data),
    .ex_imm_o         (ex_imm),
    .ex_rd_idx_o      (ex_rd_idx),
    .ex_exc_op_o      (ex_exc_op),
    .ex_alu_op_o      (ex_alu_op),
    .ex_mem_op_o      (ex_mem_op),
    .ex_ecall_o       (ex_ecall),
    .ex_ebreak_o      (ex_ebreak),
    .ex_mret_o        (ex_mret),
    .ex_illegal_o     (ex_illegal)
  );

  always #4 clk = ~clk;

  // taps for x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  // builds a legal word of one class
  // 0 lui, 1 auipc, 2 jal, 3 jalr, 4 branch, 5 load, 6 store, 7 op_imm, else op
  function automatic logic [31:0] gen_inst(input int cls);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] w;
    rd    = 5'(rand_bits(5)) & idx_mask;
    rs1   = 5'(rand_bits(5)) & idx_mask;
    rs2   = 5'(rand_bits(5)) & idx_mask;
    f3    = 3'(rand_bits(3));
    f7    = 7'(rand_bits(7));
    imm12 = 12'(rand_bits(12));
    imm20 = 20'(rand_bits(20));
    case (cls)
      0: w = {imm20, rd, OPC_LUI};
      1: w = {imm20, rd, OPC_AUIPC};
      2: w = {imm20, rd, OPC_JAL};
      3: w = {imm12, rs1, 3'b000, rd, OPC_JALR};
      4: begin
        if (f3 == 3'd2 || f3 == 3'd3)
          f3 = f3 + 3'd4;
        w = {f7, rs2, rs1, f3, rd, OPC_BRANCH};
      end
      5: begin
        if (f3 == 3'd3 || f3 >= 3'd6)
          f3 = 3'd2;
        w = {imm12, rs1, f3, rd, OPC_LOAD};
      end
      6: begin
        f3 = {1'b0, f3[1:0]};
        if (f3 == 3'd3)
          f3 = 3'd2;
        w = {f7, rs2, rs1, f3, rd, OPC_STORE};
      end
      7: begin
        if (f3 == 3'd1)
          imm12[11:5] = 7'h00;
        else if (f3 == 3'd5)
          imm12[11:5] = {1'b0, imm12[10], 5'b0};
        w = {imm12, rs1, f3, rd, OPC_OP_IMM};
      end
      default: begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && f7[0]) ? 7'h20 : 7'h00;
        w  = {f7, rs2, rs1, f3, rd, OPC_OP};
      end
    endcase
    return w;
  endfunction

  // reference decode from the RV32I encoding rules
  function automatic void model_decode(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_rd;
    f3      = w[14:12];
    f7      = w[31:25];
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    exp_exc = EXC_NONE;
    exp_alu = ALU_NONE;
    exp_mem = MEM_NONE;
    exp_imm = '0;
    case (w[6:0])
      OPC_LUI, OPC_AUIPC: begin
        exp_exc = w[5] ? EXC_LUI : EXC_AUIPC;
        exp_alu = ALU_ADD;
        use_rd  = 1'b1;
        exp_imm = {w[31:12], 12'h000};
      end
      OPC_JAL: begin
        exp_exc = EXC_JAL;
        exp_alu = ALU_ADD;
        use_rd  = 1'b1;
        exp_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR: begin
        if (f3 == 3'd0) begin
          exp_exc = EXC_JALR;
          exp_alu = ALU_ADD;
        end
      end
      OPC_BRANCH: begin
        case (f3)
          3'd0: exp_alu = ALU_BEQ;
          3'd1: exp_alu = ALU_BNE;
          3'd4: exp_alu = ALU_BLT;
          3'd5: exp_alu = ALU_BGE;
          3'd6: exp_alu = ALU_BLTU;
          3'd7: exp_alu = ALU_BGEU;
          default: exp_alu = ALU_NONE;
        endcase
        if (exp_alu != ALU_NONE) begin
          exp_exc = EXC_BRANCH;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          exp_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      OPC_LOAD: begin
        case (f3)
          3'd0: exp_mem = MEM_LB;
          3'd1: exp_mem = MEM_LH;
          3'd2: exp_mem = MEM_LW;
          3'd4: exp_mem = MEM_LBU;
          3'd5: exp_mem = MEM_LHU;
          default: exp_mem = MEM_NONE;
        endcase
        if (exp_mem != MEM_NONE) begin
          exp_exc = EXC_LOAD;
          exp_alu = ALU_ADD;
        end
      end
      OPC_STORE: begin
        if (f3 <= 3'd2) begin
          exp_mem = (f3 == 3'd0) ? MEM_SB : (f3 == 3'd1) ? MEM_SH : MEM_SW;
          exp_exc = EXC_STORE;
          exp_alu = ALU_ADD;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          exp_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        end
      end
      OPC_OP_IMM: begin
        case (f3)
          3'd0: exp_alu = ALU_ADD;
          3'd1: exp_alu = (f7 == 7'h00) ? ALU_SLL : ALU_NONE;
          3'd2: exp_alu = ALU_SLT;
          3'd3: exp_alu = ALU_SLTU;
          3'd4: exp_alu = ALU_XOR;
          3'd5: exp_alu = (f7 == 7'h00) ? ALU_SRL : (f7 == 7'h20) ? ALU_SRA : ALU_NONE;
          3'd6: exp_alu = ALU_OR;
          default: exp_alu = ALU_AND;
        endcase
        if (exp_alu != ALU_NONE)
          exp_exc = EXC_OPIMM;
      end
      OPC_OP: begin
        if (f7 == 7'h00) begin
          case (f3)
            3'd0: exp_alu = ALU_ADD;
            3'd1: exp_alu = ALU_SLL;
            3'd2: exp_alu = ALU_SLT;
            3'd3: exp_alu = ALU_SLTU;
            3'd4: exp_alu = ALU_XOR;
            3'd5: exp_alu = ALU_SRL;
            3'd6: exp_alu = ALU_OR;
            default: exp_alu = ALU_AND;
          endcase
        end else if (f7 == 7'h20 && f3 == 3'd0) begin
          exp_alu = ALU_SUB;
        end else if (f7 == 7'h20 && f3 == 3'd5) begin
          exp_alu = ALU_SRA;
        end
        if (exp_alu != ALU_NONE) begin
          exp_exc = EXC_OPREG;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          use_rd  = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        if (w == 32'h0000_0073 || w == 32'h0010_0073 || w == 32'h3020_0073)
          exp_exc = EXC_SYSTEM;
      end
      default: exp_exc = EXC_NONE;
    endcase
    // jalr, load, op_imm and system use the I form
    if (exp_exc inside {EXC_JALR, EXC_LOAD, EXC_OPIMM, EXC_SYSTEM}) begin
      use_rs1 = 1'b1;
      use_rd  = 1'b1;
      exp_imm = {{20{w[31]}}, w[31:20]};
    end
    exp_rs1     = use_rs1 ? w[19:15] : 5'd0;
    exp_rs2     = use_rs2 ? w[24:20] : 5'd0;
    exp_rd      = use_rd ? w[11:7] : 5'd0;
    exp_illegal = (exp_exc == EXC_NONE);
    exp_ecall   = (w == 32'h0000_0073);
    exp_ebreak  = (w == 32'h0010_0073);
    exp_mret    = (w == 32'h3020_0073);
    exp_call    = (exp_exc == EXC_JAL || exp_exc == EXC_JALR) && (w[11:7] != 5'd0);
  endfunction

  function automatic logic [31:0] expect_operand(input logic [4:0] idx, input logic [31:0] rf);
    if (idx == 5'd0)
      return rf;
    if (prev_valid && idx == prev_rd)
      return ex_rd_data;
    if (idx == mem_rd_addr)
      return mem_rd_data;
    return rf;
  endfunction

  // drives one word, rides out a hazard stall and checks the id/ex result
  task automatic issue_inst(input logic [31:0] word, input logic flush_in);
    logic exp_stall;
    int   waits;
    valid       = 1'b1;
    inst        = word;
    pc          = {30'(rand_bits(30)), 2'b00};
    rs1_rdata   = rand_bits(32);
    rs2_rdata   = rand_bits(32);
    ex_rd_data  = rand_bits(32);
    mem_rd_addr = 5'(rand_bits(5)) & idx_mask;
    mem_rd_data = rand_bits(32);
    flush       = flush_in;
    model_decode(word);
    exp_stall = prev_valid && (prev_exc == EXC_LOAD) && (prev_rd != 5'd0) &&
                (exp_rs1 == prev_rd || exp_rs2 == prev_rd);
    @(negedge clk);
    check_eq("rs1_idx_o", rs1_idx, exp_rs1);
    check_eq("rs2_idx_o", rs2_idx, exp_rs2);
    check_eq("stall_o", stall, exp_stall);
    waits = 0;
    while (stall && waits < 4) begin
      check_eq("ras_push_valid_o", ras_push_valid, 1'b0);
      @(posedge clk);
      #1;
      check_eq("ex_valid_o", ex_valid, 1'b0);
      // the load has moved on to mem and forwards from there
      mem_rd_addr = prev_rd;
      mem_rd_data = rand_bits(32);
      prev_valid  = 1'b0;
      prev_rd     = '0;
      prev_exc    = EXC_NONE;
      waits++;
      @(negedge clk);
    end
    if (stall) begin
      errors++;
      $display("stall_o still high after %0d cycles", waits);
    end
    last_stalls = waits;
    check_eq("ras_push_valid_o", ras_push_valid, exp_call && !flush_in);
    check_eq("ras_push_addr_o", ras_push_addr, pc + 32'd4);
    @(posedge clk);
    #1;
    check_eq("ex_valid_o", ex_valid, !flush_in);
    if (flush_in) begin
      check_eq("ex_rd_idx_o", ex_rd_idx, 5'd0);
      check_eq("ex_exc_op_o", ex_exc_op, EXC_NONE);
      check_eq("ex_illegal_o", ex_illegal, 1'b0);
    end else begin
      check_eq("ex_pc_o", ex_pc, pc);
      check_eq("ex_rd_idx_o", ex_rd_idx, exp_rd);
      check_eq("ex_imm_o", ex_imm, exp_imm);
      check_eq("ex_exc_op_o", ex_exc_op, exp_exc);
      check_eq("ex_alu_op_o", ex_alu_op, exp_alu);
      check_eq("ex_mem_op_o", ex_mem_op, exp_mem);
      check_eq("ex_rs1_data_o", ex_rs1_data, expect_operand(exp_rs1, rs1_rdata));
      check_eq("ex_rs2_data_o", ex_rs2_data, expect_operand(exp_rs2, rs2_rdata));
      check_eq("ex_ecall_o", ex_ecall, exp_ecall);
      check_eq("ex_ebreak_o", ex_ebreak, exp_ebreak);
      check_eq("ex_mret_o", ex_mret, exp_mret);
      check_eq("ex_illegal_o", ex_illegal, exp_illegal);
    end
    prev_valid = !flush_in;
    prev_rd    = flush_in ? 5'd0 : exp_rd;
    prev_exc   = flush_in ? EXC_NONE : exp_exc;
    flush      = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("test %s %0d errors", name, errors - err_start);
  endtask

  initial begin
    int          err_start;
    int          tries;
    logic [31:0] w;
    logic [31:0] dep;
    clk         = 1'b0;
    arst_n      = 1'b0;
    valid       = 1'b0;
    inst        = '0;
    pc          = '0;
    rs1_rdata   = '0;
    rs2_rdata   = '0;
    ex_rd_data  = '0;
    mem_rd_addr = '0;
    mem_rd_data = '0;
    flush       = 1'b0;
    lfsr_q      = 16'd35;
    idx_mask    = 5'h1f;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    prev_valid  = 1'b0;
    prev_rd     = '0;
    prev_exc    = EXC_NONE;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    err_start = errors;
    for (int i = 0; i < 60; i++)
      issue_inst(gen_inst(int'(rand_bits(4)) % 9), 1'b0);
    report_test("decode", err_start);

    // few registers so ex and mem hits are common
    err_start = errors;
    idx_mask  = 5'h03;
    for (int i = 0; i < 60; i++)
      issue_inst(gen_inst(4 + int'(rand_bits(3)) % 5), 1'b0);
    idx_mask = 5'h1f;
    report_test("forward", err_start);

    err_start = errors;
    for (int i = 0; i < 8; i++) begin
      w = gen_inst(5);
      if (w[11:7] == 5'd0)
        w[11:7] = 5'd1;
      issue_inst(w, 1'b0);
      dep        = gen_inst(8);
      dep[19:15] = w[11:7];
      issue_inst(dep, 1'b0);
      check_eq("stall cycles", last_stalls, 1);
    end
    report_test("loaduse", err_start);

    err_start = errors;
    issue_inst(32'h0000_0073, 1'b0);
    issue_inst(32'h0010_0073, 1'b0);
    issue_inst(32'h3020_0073, 1'b0);
    for (int i = 0; i < 10; i++) begin
      tries = 0;
      w     = rand_bits(32);
      model_decode(w);
      while (!exp_illegal && tries < 100) begin
        w = rand_bits(32);
        model_decode(w);
        tries++;
      end
      issue_inst(w, 1'b0);
    end
    report_test("traps", err_start);

    err_start = errors;
    for (int i = 0; i < 8; i++)
      issue_inst(gen_inst(i[0] ? 2 + int'(rand_bits(1)) : int'(rand_bits(4)) % 9), 1'b1);
    report_test("flush", err_start);

    err_start = errors;
    for (int i = 0; i < 12; i++) begin
      w = gen_inst(2 + int'(rand_bits(1)));
      if (rand_bits(2) == 0)
        w[11:7] = 5'd0;
      issue_inst(w, 1'b0);
    end
    report_test("calls", err_start);

    valid = 1'b0;
    @(posedge clk);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* id_stage_top.f */
common/id_pkg.sv
decoder/inst_decoder.sv
verilog/operand_bypass.sv
verilog/id_ex_reg.sv
verilog/id_stage_top.sv
bench/id_stage_checker.sv
bench/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - common/id_pkg.sv
  - decoder/inst_decoder.sv
  - verilog/operand_bypass.sv
  - verilog/id_ex_reg.sv
  - verilog/id_stage_top.sv
  - target: test
    files:
      - bench/id_stage_checker.sv
      - bench/id_stage_tb.sv
